// File: boot_rom.hex
// One 128-bit boot line per row, 32 hex digits, word 0 in the rightmost 8 digits
000002970002829330529073f1402573
0010051300a51513000005930005a023
0ff0000f000000130000001310500073
ffdff06f000000137b24107330200073
800002b70002a30300030663000300e7
00001137ff0101130011262300812423
01010413fe042623fec4278300178793
fef42623fec4270306400793fee7d6e3
00c12083008124030101011300008067
340111730011202334202573342025f3
00a1222300b124230001208334011173
30200073deadc0de13579bdf2468ace0
0badf00d000000130000001300000013
0c0ffee05a5a5a5aa5a5a5a53c3c3c3c
11111111222222223333333344444444
fedcba98765432100f1e2d3c4b5a6978

// File: boot_rom.sv
// Contents come from the boot image at simulation start or FPGA bitstream load; no write path
`timescale 1ns/1ps

module boot_rom
    import fetch_map_pkg::*, fetch_types_pkg::*;
(
    input  logic       clk_i,
    input  logic       sargantana_rstn,
    input  fetch_req_t brom_req_i,
    output line_resp_t brom_resp_o
);

    logic [LINE_W-1:0]       rom_mem [BROM_LINES];
    logic [FETCH_ADDR_W-1:0] rom_offset;
    logic [BROM_IDX_W-1:0]   line_idx;
    logic                    resp_valid_q;
    logic [LINE_W-1:0]       resp_data_q;

    initial begin
        $readmemh(BROM_FILE, rom_mem);
    end

    assign rom_offset = brom_req_i.addr - BROM_BASE;
    assign line_idx   = rom_offset[LINE_OFFSET_W +: BROM_IDX_W]; // Drop byte offset

    always_ff @(posedge clk_i, negedge sargantana_rstn) begin
        if (~sargantana_rstn) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= brom_req_i.valid;
        end
    end

    // Line register, only loaded on an accepted request
    always_ff @(posedge clk_i) begin
        if (brom_req_i.valid) begin
            resp_data_q <= rom_mem[line_idx];
        end
    end

    assign brom_resp_o.valid = resp_valid_q;
    assign brom_resp_o.data  = resp_data_q;

endmodule

// File: fetch_map_pkg.sv
// Windows must be line aligned inside a 24-bit fetch space, and queue depth must be a power of two
package fetch_map_pkg;

    // Bus widths
    localparam int FETCH_ADDR_W  = 24;
    localparam int LINE_W        = 128;
    localparam int LINE_OFFSET_W = 4;   // Byte offset inside a line, ignored on fetch

    // Boot ROM window, 16 lines
    localparam logic [FETCH_ADDR_W-1:0] BROM_BASE = 24'h000100;
    localparam logic [FETCH_ADDR_W-1:0] BROM_END  = 24'h0001FF;
    localparam int BROM_LINES = 16;
    localparam int BROM_IDX_W = $clog2(BROM_LINES);

    // Debug program buffer window, 2 lines of 4 words each
    localparam logic [FETCH_ADDR_W-1:0] PROGBUF_BASE = 24'h000800;
    localparam logic [FETCH_ADDR_W-1:0] PROGBUF_END  = 24'h00081F;
    localparam int PROGBUF_WORDS      = 8;
    localparam int PROGBUF_WORD_W     = 32;
    localparam int PROGBUF_IDX_W      = $clog2(PROGBUF_WORDS);
    localparam int WORDS_PER_LINE     = LINE_W / PROGBUF_WORD_W;
    localparam int PROGBUF_LINES      = PROGBUF_WORDS / WORDS_PER_LINE;
    localparam int PROGBUF_LINE_IDX_W = (PROGBUF_LINES > 1) ? $clog2(PROGBUF_LINES) : 1;

    // Refill path from L2
    localparam int REFILL_DEPTH = 2;    // Also the initial credit count held by L2
    localparam int REFILL_PTR_W = (REFILL_DEPTH > 1) ? $clog2(REFILL_DEPTH) : 1;
    localparam int REFILL_CNT_W = $clog2(REFILL_DEPTH + 1);
    localparam int BEAT_W       = 2;

    // Boot image, one 128-bit hex line per ROM line
    localparam string BROM_FILE = "boot_rom.hex";

endpackage

// File: fetch_resp_merge.sv
// L2 must not send a beat without a credit; only one uncached target may respond per cycle
`timescale 1ns/1ps

module fetch_resp_merge
    import fetch_map_pkg::*, fetch_types_pkg::*;
(
    input  logic         clk_i,
    input  logic         sargantana_rstn,
    input  line_resp_t   brom_resp_i,
    input  line_resp_t   progbuf_resp_i,
    input  refill_beat_t refill_i,
    output logic         refill_credit_o,
    output core_resp_t   core_resp_o
);

    logic                    uc_valid;
    logic [LINE_W-1:0]       uc_data;
    logic [LINE_W-1:0]       q_data [REFILL_DEPTH];
    logic [BEAT_W-1:0]       q_beat [REFILL_DEPTH];
    logic [REFILL_PTR_W-1:0] wr_ptr_q;
    logic [REFILL_PTR_W-1:0] rd_ptr_q;
    logic [REFILL_CNT_W-1:0] count_q;
    logic                    q_empty;
    logic                    push;
    logic                    pop;
    logic                    bypass;
    logic                    credit_q;

    function automatic logic [REFILL_PTR_W-1:0] next_ptr(input logic [REFILL_PTR_W-1:0] ptr);
        if (ptr == REFILL_PTR_W'(REFILL_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Decoder guarantees at most one uncached valid
    assign uc_valid = brom_resp_i.valid | progbuf_resp_i.valid;
    assign uc_data  = brom_resp_i.valid ? brom_resp_i.data : progbuf_resp_i.data;

    assign q_empty = (count_q == '0);
    assign pop     = !uc_valid && !q_empty;
    assign bypass  = !uc_valid && q_empty && refill_i.valid; // Straight through
    assign push    = refill_i.valid && !bypass;             // Collision or older beats waiting

    // Uncached line wins, then queue head, then a fresh beat
    always_comb begin
        if (uc_valid) begin
            core_resp_o = '{valid: 1'b1, data: uc_data, beat: '0};
        end else if (!q_empty) begin
            core_resp_o = '{valid: 1'b1, data: q_data[rd_ptr_q], beat: q_beat[rd_ptr_q]};
        end else begin
            core_resp_o = '{valid: refill_i.valid, data: refill_i.data, beat: refill_i.beat};
        end
    end

    always_ff @(posedge clk_i, negedge sargantana_rstn) begin
        if (~sargantana_rstn) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_q <= 1'b0;
        end else begin
            if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
            if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
            count_q  <= count_q + REFILL_CNT_W'(push) - REFILL_CNT_W'(pop);
            credit_q <= pop | bypass; // One credit per beat delivered
        end
    end

    // Queue storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            q_data[wr_ptr_q] <= refill_i.data;
            q_beat[wr_ptr_q] <= refill_i.beat;
        end
    end

    assign refill_credit_o = credit_q;

endmodule

// File: fetch_target_decoder.sv
// Purely combinational; ready follows the address only, so an unmapped request must be withdrawn
`timescale 1ns/1ps

module fetch_target_decoder
    import fetch_map_pkg::*, fetch_types_pkg::*;
(
    input  fetch_req_t fetch_req_i,
    output logic       fetch_ready_o,
    output fetch_req_t brom_req_o,
    output fetch_req_t progbuf_req_o
);

    fetch_target_e target;
    logic          in_brom;
    logic          in_progbuf;

    // Window checks, both bounds inclusive
    assign in_brom    = (fetch_req_i.addr >= BROM_BASE) && (fetch_req_i.addr <= BROM_END);
    assign in_progbuf = (fetch_req_i.addr >= PROGBUF_BASE) && (fetch_req_i.addr <= PROGBUF_END);

    always_comb begin
        if (in_brom) begin
            target = TGT_BROM;
        end else if (in_progbuf) begin
            target = TGT_PROGBUF;
        end else begin
            target = TGT_NONE;
        end
    end

    assign fetch_ready_o = (target != TGT_NONE);

    // Boot ROM sees the full address
    always_comb begin
        brom_req_o.valid = fetch_req_i.valid && (target == TGT_BROM);
        brom_req_o.addr  = fetch_req_i.addr;
    end

    // Program buffer works on offsets from its base
    always_comb begin
        progbuf_req_o.valid = fetch_req_i.valid && (target == TGT_PROGBUF);
        progbuf_req_o.addr  = fetch_req_i.addr - PROGBUF_BASE;
    end

endmodule

// File: fetch_types_pkg.sv
// Valid is the top bit of every struct; layouts are fixed by the widths in the map package
package fetch_types_pkg;

    import fetch_map_pkg::*;

    // Where an uncached fetch goes
    typedef enum logic [1:0] {
        TGT_NONE    = 2'b00,
        TGT_BROM    = 2'b01,
        TGT_PROGBUF = 2'b10
    } fetch_target_e;

    typedef struct packed {
        logic                    valid;
        logic [FETCH_ADDR_W-1:0] addr;
    } fetch_req_t;

    // Line from one uncached target
    typedef struct packed {
        logic              valid;
        logic [LINE_W-1:0] data;
    } line_resp_t;

    // Towards the core, beat 0 for uncached lines
    typedef struct packed {
        logic              valid;
        logic [LINE_W-1:0] data;
        logic [BEAT_W-1:0] beat;
    } core_resp_t;

    typedef struct packed {
        logic              valid;
        logic [LINE_W-1:0] data;
        logic [BEAT_W-1:0] beat;
    } refill_beat_t;

    // Debug side word write
    typedef struct packed {
        logic                      we;
        logic [PROGBUF_IDX_W-1:0]  idx;
        logic [PROGBUF_WORD_W-1:0] data;
    } progbuf_wr_t;

endpackage

// File: prog_buffer.sv
// Request address is already an offset from the buffer base; same-cycle write and read gives old data
`timescale 1ns/1ps

module prog_buffer
    import fetch_map_pkg::*, fetch_types_pkg::*;
(
    input  logic        clk_i,
    input  logic        sargantana_rstn,
    input  progbuf_wr_t progbuf_wr_i,
    input  fetch_req_t  progbuf_req_i,
    output line_resp_t  progbuf_resp_o
);

    logic [PROGBUF_WORD_W-1:0]     words_q [PROGBUF_WORDS];
    logic [PROGBUF_LINE_IDX_W-1:0] line_sel;
    logic [LINE_W-1:0]             rd_line;
    logic                          resp_valid_q;
    logic [LINE_W-1:0]             resp_data_q;

    // Debug side writes one word per cycle
    always_ff @(posedge clk_i, negedge sargantana_rstn) begin
        if (~sargantana_rstn) begin
            for (int i = 0; i < PROGBUF_WORDS; i++) begin
                words_q[i] <= '0;
            end
        end else if (progbuf_wr_i.we) begin
            words_q[progbuf_wr_i.idx] <= progbuf_wr_i.data;
        end
    end

    assign line_sel = progbuf_req_i.addr[LINE_OFFSET_W +: PROGBUF_LINE_IDX_W];

    // Gather four words, lowest word in the low bits
    always_comb begin
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            rd_line[w*PROGBUF_WORD_W +: PROGBUF_WORD_W] = words_q[line_sel*WORDS_PER_LINE + w];
        end
    end

    always_ff @(posedge clk_i, negedge sargantana_rstn) begin
        if (~sargantana_rstn) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= progbuf_req_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (progbuf_req_i.valid) begin
            resp_data_q <= rd_line; // Samples pre-write words
        end
    end

    assign progbuf_resp_o.valid = resp_valid_q;
    assign progbuf_resp_o.data  = resp_data_q;

endmodule

// File: tb_uncached_fetch.sv
// Run from the project root so boot_rom.hex is found; L2 credits start at REFILL_DEPTH
`timescale 1ns/1ps

module tb_uncached_fetch
    import fetch_map_pkg::*, fetch_types_pkg::*;
();

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 16;
    localparam int QUIET_CYCLES  = 4;
    localparam int BROM_FETCHES  = 24;
    localparam int PB_CYCLES     = PROGBUF_WORDS + 6;
    localparam int UNMAP_CYCLES  = 6;
    localparam int REFILL_CYCLES = 60;
    localparam int DRAIN_LIMIT   = 20;
    localparam int TEST_CYCLES   = RESET_CYCLES + QUIET_CYCLES + BROM_FETCHES + 3 + PB_CYCLES
                                   + UNMAP_CYCLES + 4 + REFILL_CYCLES + DRAIN_LIMIT + 1;
    localparam int MARGIN_CYCLES = 50;
    localparam int LOG_DEPTH     = 128;   // Far more than the beats sent

    logic         clk_i;
    logic         sargantana_rstn;
    fetch_req_t   fetch_req;
    logic         fetch_ready;
    progbuf_wr_t  progbuf_wr;
    refill_beat_t refill;
    logic         refill_credit;
    core_resp_t   core_resp;

    // Reference model state
    logic [LINE_W-1:0]         brom_model [BROM_LINES];
    logic [PROGBUF_WORD_W-1:0] pb_model [PROGBUF_WORDS];
    logic [LINE_W-1:0]         beat_data_log [LOG_DEPTH];
    logic [BEAT_W-1:0]         beat_num_log [LOG_DEPTH];
    int                        arrived;   // Beats seen on refill_i
    int                        shown;     // Beats already expected on core_resp_o
    int                        credits;   // Credits held by the L2 model
    line_resp_t                uc_exp_q;
    logic                      credit_exp_q;
    logic                      exp_ready;
    logic                      refill_shown;
    core_resp_t                exp_resp;
    logic                      stim_on;
    int                        seed;
    int                        beats_sent;

    uncached_fetch_top UUT (
        .clk_i           (clk_i),
        .sargantana_rstn (sargantana_rstn),
        .fetch_req_i     (fetch_req),
        .fetch_ready_o   (fetch_ready),
        .progbuf_wr_i    (progbuf_wr),
        .refill_i        (refill),
        .refill_credit_o (refill_credit),
        .core_resp_o     (core_resp)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    function automatic logic in_window(input logic [FETCH_ADDR_W-1:0] addr,
                                       input logic [FETCH_ADDR_W-1:0] lo,
                                       input logic [FETCH_ADDR_W-1:0] hi);
        return (addr >= lo) && (addr <= hi);
    endfunction

    // Line the core should get for an accepted fetch
    function automatic logic [LINE_W-1:0] expected_line(input logic [FETCH_ADDR_W-1:0] addr);
        int n;
        if (in_window(addr, BROM_BASE, BROM_END)) begin
            return brom_model[(addr - BROM_BASE) >> LINE_OFFSET_W];
        end
        n = (addr - PROGBUF_BASE) >> LINE_OFFSET_W;
        return {pb_model[4*n+3], pb_model[4*n+2], pb_model[4*n+1], pb_model[4*n]};
    endfunction

    assign exp_ready = in_window(fetch_req.addr, BROM_BASE, BROM_END)
                       || in_window(fetch_req.addr, PROGBUF_BASE, PROGBUF_END);

    // Uncached line first, then oldest waiting beat, then a fresh beat
    always_comb begin
        if (uc_exp_q.valid) begin
            exp_resp = '{valid: 1'b1, data: uc_exp_q.data, beat: '0};
        end else if (shown != arrived) begin
            exp_resp = '{valid: 1'b1, data: beat_data_log[shown], beat: beat_num_log[shown]};
        end else begin
            exp_resp = '{valid: refill.valid, data: refill.data, beat: refill.beat};
        end
    end

    assign refill_shown = !uc_exp_q.valid && ((shown != arrived) || refill.valid);

    always @(posedge clk_i or negedge sargantana_rstn) begin
        if (!sargantana_rstn) begin
            uc_exp_q     <= '0;
            credit_exp_q <= 1'b0;
            arrived      <= 0;
            shown        <= 0;
            credits      <= REFILL_DEPTH;
            for (int i = 0; i < PROGBUF_WORDS; i++) begin
                pb_model[i] <= '0;
            end
        end else begin
            uc_exp_q.valid <= fetch_req.valid && exp_ready;
            if (fetch_req.valid && exp_ready) begin
                uc_exp_q.data <= expected_line(fetch_req.addr); // Old words on a same-cycle write
            end
            if (progbuf_wr.we) begin
                pb_model[progbuf_wr.idx] <= progbuf_wr.data;
            end
            if (refill.valid) begin
                beat_data_log[arrived] <= refill.data;
                beat_num_log[arrived]  <= refill.beat;
                arrived                <= arrived + 1;
            end
            shown        <= shown + int'(refill_shown);
            credit_exp_q <= refill_shown;   // Pulse follows each delivered beat
            credits      <= credits - int'(refill.valid) + int'(refill_credit);
        end
    end

    task automatic report_failure(input string msg);
        $display("FAILED at time %0t: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "Stopping at first mismatch");
    endtask

    quiet_check: assert property (@(posedge clk_i) !stim_on |-> (!core_resp.valid && !refill_credit))
        else report_failure("response or credit seen before any stimulus");
    ready_check: assert property (@(posedge clk_i) fetch_ready == exp_ready)
        else report_failure("fetch_ready_o does not follow the address map");
    valid_check: assert property (@(posedge clk_i) core_resp.valid == exp_resp.valid)
        else report_failure("core_resp_o valid differs from the model");
    payload_check: assert property (@(posedge clk_i) exp_resp.valid |-> core_resp == exp_resp)
        else report_failure("core_resp_o data or beat differs from the model");
    credit_check: assert property (@(posedge clk_i) refill_credit == credit_exp_q)
        else report_failure("refill_credit_o pulse in the wrong cycle");

    task automatic next_cycle();
        @(posedge clk_i);
        #1;   // Inputs change away from the edge
    endtask

    task automatic fetch_brom();
        fetch_req = '{valid: 1'b1, addr: BROM_BASE + FETCH_ADDR_W'($random(seed) & 32'hFF)};
    endtask

    task automatic send_beat();
        refill = '{valid: 1'b1,
                   data: {$random(seed), $random(seed), $random(seed), $random(seed)},
                   beat: BEAT_W'(beats_sent)};
        beats_sent++;
    endtask

    initial begin
        seed            = 32'h0d235d1b;
        sargantana_rstn = 1'b1;
        stim_on         = 1'b0;
        fetch_req       = '0;
        progbuf_wr      = '0;
        refill          = '0;
        beats_sent      = 0;
        $readmemh("boot_rom.hex", brom_model);
        #1;
        sargantana_rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        sargantana_rstn = 1'b1;
        repeat (QUIET_CYCLES) next_cycle();
        stim_on = 1'b1;

        // Back-to-back boot ROM fetches
        for (int i = 0; i < BROM_FETCHES; i++) begin
            fetch_brom();
            next_cycle();
        end
        fetch_req = '0;
        repeat (3) next_cycle();

        // Debug words, then both program buffer lines
        for (int i = 0; i < PROGBUF_WORDS; i++) begin
            progbuf_wr = '{we: 1'b1, idx: PROGBUF_IDX_W'(i), data: $random(seed)};
            next_cycle();
        end
        progbuf_wr = '0;
        fetch_req  = '{valid: 1'b1, addr: PROGBUF_BASE + FETCH_ADDR_W'($random(seed) & 32'hF)};
        next_cycle();
        fetch_req  = '{valid: 1'b1, addr: PROGBUF_BASE + 24'h10};
        progbuf_wr = '{we: 1'b1, idx: 3'd4, data: $random(seed)};  // Same-cycle write
        next_cycle();
        progbuf_wr = '0;
        fetch_req  = '{valid: 1'b1, addr: PROGBUF_END};
        next_cycle();
        fetch_req = '0;
        repeat (3) next_cycle();

        // Unmapped addresses, withdrawn after a while
        fetch_req = '{valid: 1'b1, addr: 24'h400000 | FETCH_ADDR_W'($random(seed) & 32'hFFFF)};
        repeat (3) next_cycle();
        fetch_req = '{valid: 1'b1, addr: BROM_END + 24'h1};
        next_cycle();
        fetch_req = '{valid: 1'b1, addr: PROGBUF_END + 24'h1};
        next_cycle();
        fetch_req = '0;
        next_cycle();

        // Two beats that both hit an uncached response
        fetch_brom();
        next_cycle();
        fetch_brom();
        send_beat();
        next_cycle();
        fetch_req = '0;
        send_beat();
        next_cycle();
        refill = '0;
        next_cycle();

        // Random mix of fetches and credited beats
        for (int i = 0; i < REFILL_CYCLES; i++) begin
            if ($random(seed) & 1) begin
                fetch_brom();
            end else begin
                fetch_req = '0;
            end
            if ((credits > 0) && ($random(seed) & 1)) begin
                send_beat();
            end else begin
                refill = '0;
            end
            next_cycle();
        end
        fetch_req = '0;
        refill    = '0;

        // Queue drains and every credit comes home
        for (int i = 0; (i < DRAIN_LIMIT) && (credits != REFILL_DEPTH); i++) begin
            next_cycle();
        end
        next_cycle();
        if ((credits != REFILL_DEPTH) || (shown != arrived)) begin
            $display("Refill queue did not drain: %0d credits held, %0d beats undelivered",
                     credits, arrived - shown);
            $display("Errors found");
            $fatal(1, "Refill credits not returned");
        end else begin
            $display("No errors");
            $finish;
        end
    end

    // Watchdog
    initial begin
        #(CLK_PERIOD * (TEST_CYCLES + MARGIN_CYCLES));
        $display("Timeout: the test did not finish within %0d cycles",
                 TEST_CYCLES + MARGIN_CYCLES);
        $display("Errors found");
        $fatal(1, "Watchdog expired");
    end

endmodule

// File: uncached_fetch_top.sv
// Single-hart fetch path; the core takes every response, L2 paces refills by the credit pulses
`timescale 1ns/1ps

module uncached_fetch_top
    import fetch_types_pkg::*;
(
    input  logic         clk_i,
    input  logic         sargantana_rstn,
    input  fetch_req_t   fetch_req_i,
    output logic         fetch_ready_o,
    input  progbuf_wr_t  progbuf_wr_i,
    input  refill_beat_t refill_i,
    output logic         refill_credit_o,
    output core_resp_t   core_resp_o
);

    fetch_req_t brom_req;
    fetch_req_t progbuf_req;
    line_resp_t brom_resp;
    line_resp_t progbuf_resp;

    // Address decode and routing
    fetch_target_decoder u_decoder (
        .fetch_req_i   (fetch_req_i),
        .fetch_ready_o (fetch_ready_o),
        .brom_req_o    (brom_req),
        .progbuf_req_o (progbuf_req)
    );

    boot_rom u_brom (
        .clk_i           (clk_i),
        .sargantana_rstn (sargantana_rstn),
        .brom_req_i      (brom_req),
        .brom_resp_o     (brom_resp)
    );

    // Debug program buffer
    prog_buffer u_progbuf (
        .clk_i           (clk_i),
        .sargantana_rstn (sargantana_rstn),
        .progbuf_wr_i    (progbuf_wr_i),
        .progbuf_req_i   (progbuf_req),
        .progbuf_resp_o  (progbuf_resp)
    );

    // Uncached lines and icache refills into one stream
    fetch_resp_merge u_merge (
        .clk_i           (clk_i),
        .sargantana_rstn (sargantana_rstn),
        .brom_resp_i     (brom_resp),
        .progbuf_resp_i  (progbuf_resp),
        .refill_i        (refill_i),
        .refill_credit_o (refill_credit_o),
        .core_resp_o     (core_resp_o)
    );

endmodule

// File: vlog.f
fetch_map_pkg.sv
fetch_types_pkg.sv
fetch_target_decoder.sv
boot_rom.sv
prog_buffer.sv
fetch_resp_merge.sv
uncached_fetch_top.sv
tb_uncached_fetch.sv
